// File: tb.f
npc_pkg.sv
npc_ifs.sv
fetch_unit.sv
hazard_unit.sv
decoder.sv
regfile.sv
stage_reg.sv
alu.sv
npc_pipeline.sv
tb_npc_pipeline.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module tb_npc_pipeline -o sim_npc

run: compile
	@out="$$(./obj_dir/sim_npc)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF ">>> PASS"

clean:
	rm -rf obj_dir

// File: tb_npc_pipeline.sv
`default_nettype none

module tb_npc_pipeline import npc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t reset_pc = 32'h3000_0000;
    localparam int    prog_len = 200;
    // 3 fetch cycles plus 4 hazard cycles per instruction, with margin
    localparam int    timeout_cycles = (prog_len + 1) * (3 + 4) + 50;

    logic     clk;
    logic     rst;
    logic     ifu_req;
    word_t    ifu_addr;
    logic     ifu_rvalid;
    word_t    ifu_rdata;
    logic     commit_valid;
    word_t    commit_pc;
    logic     commit_wen;
    reg_idx_t commit_rd;
    word_t    commit_data;
    logic     ebreak_flag;
    word_t    exit_code;

    // Program image and expected retire list
    word_t    program_mem [0:prog_len];
    logic     exp_wen     [0:prog_len];
    reg_idx_t exp_rd      [0:prog_len];
    word_t    exp_data    [0:prog_len];
    word_t    model_regs  [0:31];

    int    error_count;
    int    check_count;
    int    commit_count;
    int    fetch_count;
    int    cycle_count;
    int    resp_wait;
    logic  ebreak_done;
    logic  ebreak_prev;
    logic  pending;
    word_t pend_addr;

    npc_pipeline #(.reset_pc(reset_pc)) uut (
        .clk          (clk),
        .rst          (rst),
        .ifu_req      (ifu_req),
        .ifu_addr     (ifu_addr),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rdata    (ifu_rdata),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .ebreak_flag  (ebreak_flag),
        .exit_code    (exit_code)
    );

    task automatic check_value(input word_t got, input word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, op_lui};
    endfunction

    // Mostly x1..x4 and x10 so that dependencies are close together
    function automatic reg_idx_t pick_reg();
        int r;
        r = int'($urandom_range(9, 0));
        if (r == 0) begin
            return 5'd0;
        end
        if (r == 9) begin
            return reg_idx_t'($urandom_range(31, 0));
        end
        case ((r - 1) % 5)
            0:       return 5'd1;
            1:       return 5'd2;
            2:       return 5'd3;
            3:       return 5'd4;
            default: return a0_idx;
        endcase
    endfunction

    function automatic word_t random_inst();
        int          kind;
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic        alt;
        kind = int'($urandom_range(19, 0));
        f3   = 3'($urandom_range(7, 0));
        imm  = 12'($urandom_range(4095, 0));
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        if (kind < 2) begin
            return enc_u(20'($urandom), rd);
        end
        // slli with funct7 set is not RV32I and must retire as a no-op
        if (kind == 2) begin
            return enc_i({f7_alt, imm[4:0]}, rs1, f3_sll, rd);
        end
        if (kind < 11) begin
            if (f3 == f3_sll) begin
                imm[11:5] = f7_base;
            end else if (f3 == f3_srl_sra) begin
                imm[11:5] = imm[11] ? f7_alt : f7_base;
            end
            return enc_i(imm, rs1, f3, rd);
        end
        alt = imm[0] && ((f3 == f3_add_sub) || (f3 == f3_srl_sra));
        return enc_r(alt ? f7_alt : f7_base, rs2, rs1, f3, rd);
    endfunction

    function automatic word_t apply_op(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
        case (f3)
            f3_add_sub: return alt ? a - b : a + b;
            f3_sll:     return a << b[4:0];
            f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_sltu:    return (a < b) ? 32'd1 : 32'd0;
            f3_xor:     return a ^ b;
            f3_srl_sra: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            f3_or:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // ISA model step for one instruction in program order
    task automatic model_step(input int idx);
        word_t      inst;
        logic [6:0] f7;
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      result;
        logic       legal;
        logic       alt;
        inst   = program_mem[idx];
        f7     = inst[31:25];
        f3     = inst[14:12];
        rd     = inst[11:7];
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        imm    = {{20{inst[31]}}, inst[31:20]};
        legal  = 1'b0;
        result = '0;
        case (inst[6:0])
            op_lui: begin
                legal  = 1'b1;
                result = {inst[31:12], 12'b0};
            end
            op_imm: begin
                alt = (f3 == f3_srl_sra) && (f7 == f7_alt);
                if (f3 == f3_sll) begin
                    legal = (f7 == f7_base);
                end else if (f3 == f3_srl_sra) begin
                    legal = (f7 == f7_base) || (f7 == f7_alt);
                end else begin
                    legal = 1'b1;
                end
                result = apply_op(f3, alt, a, imm);
            end
            op_reg: begin
                alt    = (f7 == f7_alt);
                legal  = (f7 == f7_base) ||
                         (alt && ((f3 == f3_add_sub) || (f3 == f3_srl_sra)));
                result = apply_op(f3, alt, a, b);
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        exp_wen[idx]  = legal && (rd != 5'd0);
        exp_rd[idx]   = rd;
        exp_data[idx] = result;
        if (exp_wen[idx]) begin
            model_regs[rd] = result;
        end
    endtask

    task automatic build_program();
        // Known starting values before the random part
        program_mem[0] = enc_u(20'h12345, 5'd1);
        program_mem[1] = enc_i(12'h678, 5'd1, f3_add_sub, 5'd1);
        program_mem[2] = enc_i(12'hffb, 5'd0, f3_add_sub, 5'd2);
        program_mem[3] = enc_u(20'h80000, 5'd3);
        program_mem[4] = enc_i(12'h07f, 5'd0, f3_add_sub, 5'd4);
        program_mem[5] = enc_i(12'h00a, 5'd0, f3_add_sub, a0_idx);
        for (int i = 6; i < prog_len; i++) begin
            program_mem[i] = random_inst();
        end
        program_mem[prog_len] = ebreak_word;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i <= prog_len; i++) begin
            model_step(i);
        end
    endtask

    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - reset_pc) >> 2;
        if (idx <= word_t'(prog_len)) begin
            return program_mem[idx];
        end
        return nop_word;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction memory answering 1 to 3 cycles after each request
    always @(posedge clk) begin
        ifu_rvalid <= 1'b0;
        if (!rst && ifu_req) begin
            check_value(word_t'(pending || ifu_rvalid), 32'd0,
                        "second request while one is outstanding");
            check_value(ifu_addr, reset_pc + word_t'(4 * fetch_count), "fetch address");
            fetch_count++;
            pend_addr = ifu_addr;
            resp_wait = int'($urandom_range(3, 1));
            pending   = 1'b1;
        end
        if (pending) begin
            resp_wait--;
            if (resp_wait == 0) begin
                ifu_rvalid <= 1'b1;
                ifu_rdata  <= fetch_word(pend_addr);
                pending = 1'b0;
            end
        end
    end

    // Retire trace against the model
    always @(posedge clk) begin
        if (!rst && commit_valid && !ebreak_done) begin
            check_value(commit_pc, reset_pc + word_t'(4 * commit_count),
                        "commit pc out of program order");
            check_value(word_t'(ebreak_flag), 32'd0, "ebreak_flag high before the ebreak");
            if (commit_count <= prog_len) begin
                check_value(word_t'(commit_wen), word_t'(exp_wen[commit_count]),
                            $sformatf("commit_wen at pc %h", commit_pc));
                check_value(word_t'(commit_rd), word_t'(exp_rd[commit_count]),
                            $sformatf("commit_rd at pc %h", commit_pc));
                if (exp_wen[commit_count]) begin
                    check_value(commit_data, exp_data[commit_count],
                                $sformatf("commit_data at pc %h", commit_pc));
                end
            end
            if (commit_pc == reset_pc + word_t'(4 * prog_len)) begin
                ebreak_done = 1'b1;
            end
            commit_count++;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (cycle_count > timeout_cycles) begin
                $display("Timeout: no ebreak after %0d cycles, the pipeline is hung",
                         cycle_count);
                $display("Checks: %0d, errors: %0d", check_count, error_count);
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(37));
        rst          = 1'b1;
        ifu_rvalid   = 1'b0;
        ifu_rdata    = '0;
        error_count  = 0;
        check_count  = 0;
        commit_count = 0;
        fetch_count  = 0;
        cycle_count  = 0;
        resp_wait    = 0;
        pending      = 1'b0;
        ebreak_done  = 1'b0;
        ebreak_prev  = 1'b0;
        pend_addr    = '0;
        build_program();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        while (!ebreak_flag) begin
            // The flag follows the ebreak commit by one cycle
            check_value(word_t'(ebreak_prev), 32'd0,
                        "ebreak_flag still low the cycle after the ebreak commit");
            ebreak_prev = commit_valid && (commit_pc == reset_pc + word_t'(4 * prog_len));
            @(posedge clk);
        end
        check_value(word_t'(ebreak_done), 32'd1, "ebreak_flag without an ebreak commit");
        check_value(word_t'(commit_count), word_t'(prog_len + 1), "number of commits");
        check_value(exit_code, model_regs[a0_idx], "exit code");
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: npc_pipeline.sv
`default_nettype none

module npc_pipeline import npc_pkg::*; #(
    parameter word_t reset_pc = 32'h3000_0000
) (
    input  logic     clk,
    input  logic     rst,
    output logic     ifu_req,
    output word_t    ifu_addr,
    input  logic     ifu_rvalid,
    input  word_t    ifu_rdata,
    output logic     commit_valid,
    output word_t    commit_pc,
    output logic     commit_wen,
    output reg_idx_t commit_rd,
    output word_t    commit_data,
    output logic     ebreak_flag,
    output word_t    exit_code
);

    fetch_bus fbus ();
    wb_bus    wbus ();

    // Decode outputs for the instruction in IF/ID
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    reg_idx_t id_rd;
    logic     id_uses_rs1;
    logic     id_uses_rs2;
    logic     id_use_imm;
    logic     id_reg_wen;
    logic     id_is_ebreak;
    word_t    id_imm;
    alu_op_t  id_alu_op;

    word_t rf_rdata1;
    word_t rf_rdata2;
    word_t rf_a0;
    word_t a0_now;
    logic  stall;

    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    logic    id_ex_valid;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    ex_mem_valid;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    logic    mem_wb_valid;
    word_t   alu_result;

    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .ifu_req    (ifu_req),
        .ifu_addr   (ifu_addr),
        .ifu_rvalid (ifu_rvalid),
        .ifu_rdata  (ifu_rdata),
        .fetch      (fbus.fetch)
    );

    decoder u_decoder (
        .inst      (fbus.inst),
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .uses_rs1  (id_uses_rs1),
        .uses_rs2  (id_uses_rs2),
        .rd        (id_rd),
        .imm       (id_imm),
        .use_imm   (id_use_imm),
        .alu_op    (id_alu_op),
        .reg_wen   (id_reg_wen),
        .is_ebreak (id_is_ebreak)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .wb     (wbus.consumer),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .a0     (rf_a0)
    );

    hazard_unit u_hazard (
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .uses_rs1  (id_uses_rs1),
        .uses_rs2  (id_uses_rs2),
        .ex_valid  (id_ex_valid),
        .ex_wen    (id_ex_q.reg_wen),
        .ex_rd     (id_ex_q.rd),
        .mem_valid (ex_mem_valid),
        .mem_wen   (ex_mem_q.reg_wen),
        .mem_rd    (ex_mem_q.rd),
        .wb        (wbus.consumer),
        .stall     (stall)
    );

    // A stalled instruction stays in IF/ID and EX gets a bubble
    assign fbus.take = fbus.valid && !stall;

    always_comb begin
        id_ex_d.pc        = fbus.pc;
        id_ex_d.op_a      = rf_rdata1;
        id_ex_d.op_b      = id_use_imm ? id_imm : rf_rdata2;
        id_ex_d.alu_op    = id_alu_op;
        id_ex_d.rd        = id_rd;
        id_ex_d.reg_wen   = id_reg_wen;
        id_ex_d.is_ebreak = id_is_ebreak;
    end

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fbus.take),
        .in_data   (id_ex_d),
        .out_valid (id_ex_valid),
        .out_data  (id_ex_q)
    );

    alu u_alu (
        .op     (id_ex_q.alu_op),
        .a      (id_ex_q.op_a),
        .b      (id_ex_q.op_b),
        .result (alu_result)
    );

    always_comb begin
        ex_mem_d.pc        = id_ex_q.pc;
        ex_mem_d.result    = alu_result;
        ex_mem_d.rd        = id_ex_q.rd;
        ex_mem_d.reg_wen   = id_ex_q.reg_wen;
        ex_mem_d.is_ebreak = id_ex_q.is_ebreak;
    end

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (id_ex_valid),
        .in_data   (ex_mem_d),
        .out_valid (ex_mem_valid),
        .out_data  (ex_mem_q)
    );

    // MEM only carries the result forward
    always_comb begin
        mem_wb_d.pc        = ex_mem_q.pc;
        mem_wb_d.result    = ex_mem_q.result;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.reg_wen   = ex_mem_q.reg_wen;
        mem_wb_d.is_ebreak = ex_mem_q.is_ebreak;
    end

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ex_mem_valid),
        .in_data   (mem_wb_d),
        .out_valid (mem_wb_valid),
        .out_data  (mem_wb_q)
    );

    // Writeback and retire trace
    assign wbus.valid = mem_wb_valid;
    assign wbus.wen   = mem_wb_q.reg_wen;
    assign wbus.rd    = mem_wb_q.rd;
    assign wbus.data  = mem_wb_q.result;

    assign commit_valid = mem_wb_valid;
    assign commit_pc    = mem_wb_q.pc;
    assign commit_wen   = mem_wb_q.reg_wen;
    assign commit_rd    = mem_wb_q.rd;
    assign commit_data  = mem_wb_q.result;

    // x10 as seen after this instruction's own write
    assign a0_now = (wbus.wen && (wbus.rd == a0_idx)) ? wbus.data : rf_a0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ebreak_flag <= 1'b0;
            exit_code   <= '0;
        end else if (mem_wb_valid && mem_wb_q.is_ebreak && !ebreak_flag) begin
            ebreak_flag <= 1'b1;
            exit_code   <= a0_now;
        end
    end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu import npc_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            // Arithmetic shift keeps the sign
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            // LUI immediate passes straight through
            default:  result = b;
        endcase
    end

endmodule

`default_nettype wire

// File: stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // A bubble leaves the old payload in place
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile import npc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    wb_bus.consumer  wb,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    output word_t    a0
);

    // x0 has no storage
    word_t regs [1:31];

    function automatic word_t read_reg(input reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.wen && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Old value is returned during a write to the same index
    always_comb begin
        rdata1 = read_reg(raddr1);
        rdata2 = read_reg(raddr2);
    end

    assign a0 = regs[a0_idx];

endmodule

`default_nettype wire

// File: decoder.sv
`default_nettype none

module decoder import npc_pkg::*; (
    input  word_t    inst,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output logic     uses_rs1,
    output logic     uses_rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output logic     use_imm,
    output alu_op_t  alu_op,
    output logic     reg_wen,
    output logic     is_ebreak
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    // funct3 picks the operation, alt selects sub or sra
    function automatic alu_op_t op_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            f3_add_sub: return alt ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return alt ? alu_sra : alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign rd        = inst[11:7];
    assign is_ebreak = (inst == ebreak_word);

    always_comb begin
        legal    = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        use_imm  = 1'b0;
        imm      = '0;
        alu_op   = alu_add;
        case (opcode)
            op_lui: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm     = {inst[31:12], 12'b0};
                alu_op  = alu_pass_b;
            end
            op_imm: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:20]};
                alu_op   = op_from_funct3(funct3,
                                          (funct3 == f3_srl_sra) && (funct7 == f7_alt));
                // Shift amounts above 31 are not RV32I
                if (funct3 == f3_sll) begin
                    legal = (funct7 == f7_base);
                end else if (funct3 == f3_srl_sra) begin
                    legal = (funct7 == f7_base) || (funct7 == f7_alt);
                end else begin
                    legal = 1'b1;
                end
            end
            op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                alu_op   = op_from_funct3(funct3, funct7 == f7_alt);
                legal    = (funct7 == f7_base) ||
                           ((funct7 == f7_alt) &&
                            ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
            end
            op_system: begin
                legal = is_ebreak;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Unknown encodings fall through as a no-op
    assign reg_wen = legal && (rd != '0);

endmodule

`default_nettype wire

// File: hazard_unit.sv
`default_nettype none

module hazard_unit import npc_pkg::*; (
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     uses_rs1,
    input  logic     uses_rs2,
    input  logic     ex_valid,
    input  logic     ex_wen,
    input  reg_idx_t ex_rd,
    input  logic     mem_valid,
    input  logic     mem_wen,
    input  reg_idx_t mem_rd,
    wb_bus.consumer  wb,
    output logic     stall
);

    logic ex_write;
    logic mem_write;
    logic wb_write;
    logic rs1_busy;
    logic rs2_busy;

    function automatic logic hits(input reg_idx_t src, input logic write, input reg_idx_t dst);
        return write && (src == dst);
    endfunction

    assign ex_write  = ex_valid && ex_wen;
    assign mem_write = mem_valid && mem_wen;
    // WB counts too since the register file is updated only at the end of that cycle
    assign wb_write  = wb.valid && wb.wen;

    // x0 never carries a dependency
    assign rs1_busy = uses_rs1 && (rs1 != '0) &&
                      (hits(rs1, ex_write, ex_rd) ||
                       hits(rs1, mem_write, mem_rd) ||
                       hits(rs1, wb_write, wb.rd));

    assign rs2_busy = uses_rs2 && (rs2 != '0) &&
                      (hits(rs2, ex_write, ex_rd) ||
                       hits(rs2, mem_write, mem_rd) ||
                       hits(rs2, wb_write, wb.rd));

    assign stall = rs1_busy || rs2_busy;

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit import npc_pkg::*; #(
    parameter word_t reset_pc = 32'h3000_0000
) (
    input  logic  clk,
    input  logic  rst,
    output logic  ifu_req,
    output word_t ifu_addr,
    input  logic  ifu_rvalid,
    input  word_t ifu_rdata,
    fetch_bus.fetch fetch
);

    word_t pc;
    logic  waiting;
    logic  ifid_valid;
    word_t ifid_pc;
    word_t ifid_inst;
    logic  can_request;
    logic  resp_accept;

    // Only one request in flight, and only when IF/ID will have room
    assign can_request = !waiting && (!ifid_valid || fetch.take);
    assign resp_accept = waiting && ifu_rvalid;

    assign ifu_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= reset_pc;
            ifu_req    <= 1'b0;
            waiting    <= 1'b0;
            ifid_valid <= 1'b0;
        end else begin
            // Request is a single-cycle pulse
            ifu_req <= can_request;

            if (fetch.take) begin
                ifid_valid <= 1'b0;
            end

            if (resp_accept) begin
                waiting    <= 1'b0;
                ifid_valid <= 1'b1;
                pc         <= pc + 32'd4;
            end

            if (can_request) begin
                waiting <= 1'b1;
            end
        end
    end

    // Response word paired with the address it was fetched from
    always_ff @(posedge clk) begin
        if (resp_accept) begin
            ifid_pc   <= pc;
            ifid_inst <= ifu_rdata;
        end
    end

    assign fetch.valid = ifid_valid;
    assign fetch.pc    = ifid_pc;
    assign fetch.inst  = ifid_inst;

endmodule

`default_nettype wire

// File: npc_ifs.sv
`default_nettype none

// IF/ID register contents offered to the issue logic
interface fetch_bus import npc_pkg::*; ();
    logic  valid;
    word_t pc;
    word_t inst;
    // Instruction leaves IF/ID on this edge
    logic  take;

    modport fetch (
        output valid, pc, inst,
        input  take
    );

    modport issue (
        input  valid, pc, inst,
        output take
    );
endinterface

// Register write of the instruction in WB
interface wb_bus import npc_pkg::*; ();
    logic     valid;
    logic     wen;
    reg_idx_t rd;
    word_t    data;

    modport producer (
        output valid, wen, rd, data
    );

    modport consumer (
        input valid, wen, rd, data
    );
endinterface

`default_nettype wire

// File: npc_pkg.sv
`default_nettype none

package npc_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    localparam word_t ebreak_word = 32'h0010_0073;
    // addi x0, x0, 0
    localparam word_t nop_word    = 32'h0000_0013;

    // a0 carries the exit code
    localparam reg_idx_t a0_idx = 5'd10;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        word_t    pc;
        word_t    op_a;
        word_t    op_b;
        alu_op_t  alu_op;
        reg_idx_t rd;
        logic     reg_wen;
        logic     is_ebreak;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t rd;
        logic     reg_wen;
        logic     is_ebreak;
    } ex_mem_t;

    // Kept apart from ex_mem_t so the MEM stage can add fields
    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t rd;
        logic     reg_wen;
        logic     is_ebreak;
    } mem_wb_t;

endpackage

`default_nettype wire
